//--- ewb_tests.txt
# E addr seed | L tag write seed | C reg data | R reg expected | D beats | T name
# all fields hex, a line is its 32-bit seed repeated eight times
T burst_order
E 00001000 a1a1a1a1
E 00001020 b2b2b2b2
E 00001040 c3c3c3c3
E 00001060 d4d4d4d4
E 00001080 e5e5e5e5
D 5
R 1 0020
T fill_then_drain
C 0 10
E 00002000 01010101
E 00002020 02020202
E 00002040 03030303
E 00002060 04040404
E 00002080 05050505
E 000020a0 06060606
E 000020c0 07070707
E 000020e0 08080808
R 1 0018
C 0 11
D 8
R 1 0020
R 2 000d
T threshold
C 0 41
R 0 0041
E 00003000 31313131
E 00003020 32323232
E 00003040 33333333
E 00003060 34343434
D 4
C 0 11
R 2 0011
T lookup
C 0 10
E 00004000 11111111
E 00004020 22222222
E 00004000 33333333
L 200 0 0
L 201 0 0
L 3ff 0 0
T lookup_write
L 201 1 55555555
L 201 0 0
L 200 1 66666666
L 200 0 0
C 0 11
D 3
R 1 0020
R 2 0014

//--- project.f
+incdir+.
ewb_types_pkg.sv
ewb_cfg_pkg.sv
ewb_queue.sv
ewb_cfg_regs.sv
ewb_top.sv
tb_ewb.sv

//--- tb_ewb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ewb_consts.svh"

module tb_ewb;

    localparam int WAIT_LIMIT = 200;

    logic                                     clk = 1'b0;
    logic                                     rst;
    logic                                     evict_valid_i;
    logic                                     evict_ready_o;
    logic [`EWB_ADDR_BITS-1:0]                evict_addr_i;
    logic [`EWB_LINE_BITS-1:0]                evict_data_i;
    logic                                     lookup_valid_i;
    logic [`EWB_ADDR_BITS-`EWB_OFFSET_BITS-1:0] lookup_tag_i;
    logic                                     lookup_write_i;
    logic [`EWB_LINE_BITS-1:0]                lookup_wdata_i;
    logic                                     lookup_hit_o;
    logic [`EWB_LINE_BITS-1:0]                lookup_data_o;
    logic                                     mem_valid_o;
    logic                                     mem_ready_i;
    logic [`EWB_ADDR_BITS-1:0]                mem_addr_o;
    logic [`EWB_LINE_BITS-1:0]                mem_data_o;
    logic                                     cfg_we_i;
    logic [`EWB_CFG_ADDR_BITS-1:0]            cfg_addr_i;
    logic [`EWB_CFG_WDATA_BITS-1:0]           cfg_wdata_i;
    logic [`EWB_CFG_RDATA_BITS-1:0]           cfg_rdata_o;

    // reference queue with the oldest entry at index 0.
    logic [`EWB_ADDR_BITS-1:0] model_addr [$];
    logic [`EWB_LINE_BITS-1:0] model_data [$];
    logic                      model_en;
    logic [3:0]                model_thr;
    // a drain burst runs from the first offered beat until the queue is empty.
    logic                      model_burst;

    logic [31:0]   lfsr;
    int            errors;
    int            test_errors;
    int            tests_run;
    int            tests_failed;
    int            beats_accepted;
    logic          test_active;
    logic          timed_out;
    reg [8*32-1:0] test_name;

    ewb_top dut (
        .clk(clk), .rst(rst),
        .evict_valid_i(evict_valid_i), .evict_ready_o(evict_ready_o),
        .evict_addr_i(evict_addr_i), .evict_data_i(evict_data_i),
        .lookup_valid_i(lookup_valid_i), .lookup_tag_i(lookup_tag_i),
        .lookup_write_i(lookup_write_i), .lookup_wdata_i(lookup_wdata_i),
        .lookup_hit_o(lookup_hit_o), .lookup_data_o(lookup_data_o),
        .mem_valid_o(mem_valid_o), .mem_ready_i(mem_ready_i),
        .mem_addr_o(mem_addr_o), .mem_data_o(mem_data_o),
        .cfg_we_i(cfg_we_i), .cfg_addr_i(cfg_addr_i),
        .cfg_wdata_i(cfg_wdata_i), .cfg_rdata_o(cfg_rdata_o)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            lfsr_next = (s >> 1) ^ 32'h80200003;
        end else begin
            lfsr_next = s >> 1;
        end
    endfunction

    // mem_valid_o as predicted from the model state.
    function automatic logic expect_mem_valid();
        int thr;
        thr = (model_thr == 4'd0) ? 1 : int'(model_thr);
        return (model_addr.size() > 0)
            && (model_burst || (model_en && (model_addr.size() >= thr)));
    endfunction

    task automatic check_hex(input string name, input logic [255:0] exp,
                             input logic [255:0] act);
        if (exp !== act) begin
            $display("error: %s expected %0h got %0h", name, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic evict_line(input logic [31:0] addr, input logic [31:0] seed);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!evict_ready_o && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!evict_ready_o) begin
            $display("timeout: evict_ready_o stayed low for address %h", addr);
            errors++;
            test_errors++;
            timed_out = 1'b1;
        end else begin
            @(posedge clk);
            evict_valid_i <= 1'b1;
            evict_addr_i  <= addr;
            evict_data_i  <= {8{seed}};
            @(posedge clk);
            evict_valid_i <= 1'b0;
            model_addr.push_back(addr);
            model_data.push_back({8{seed}});
            @(negedge clk);
            check_hex("evict_ready_o", model_addr.size() < `EWB_DEPTH, evict_ready_o);
            check_hex("mem_valid_o", expect_mem_valid(), mem_valid_o);
            model_burst = expect_mem_valid();
        end
    endtask

    task automatic lookup_line(input logic [26:0] tag, input logic wr, input logic [31:0] seed);
        logic                      hit;
        logic [`EWB_LINE_BITS-1:0] data;
        hit  = 1'b0;
        data = '0;
        @(posedge clk);
        lookup_valid_i <= 1'b1;
        lookup_tag_i   <= tag;
        lookup_write_i <= wr;
        lookup_wdata_i <= {8{seed}};
        // the newest match overrides older ones.
        for (int i = 0; i < model_addr.size(); i++) begin
            if (model_addr[i][31:5] == tag) begin
                hit  = 1'b1;
                data = model_data[i];
            end
        end
        @(negedge clk);
        check_hex("lookup_hit_o", hit, lookup_hit_o);
        if (hit) begin
            check_hex("lookup_data_o", data, lookup_data_o);
        end
        if (wr) begin
            for (int i = 0; i < model_addr.size(); i++) begin
                if (model_addr[i][31:5] == tag) begin
                    model_data[i] = {8{seed}};
                end
            end
        end
        @(posedge clk);
        lookup_valid_i <= 1'b0;
        lookup_write_i <= 1'b0;
    endtask

    task automatic write_reg(input logic [1:0] addr, input logic [7:0] data);
        @(posedge clk);
        cfg_we_i    <= 1'b1;
        cfg_addr_i  <= addr;
        cfg_wdata_i <= data;
        @(posedge clk);
        cfg_we_i <= 1'b0;
        if (addr == 2'd0) begin
            model_en    = data[0];
            model_thr   = data[7:4];
            model_burst = expect_mem_valid();
        end
    endtask

    task automatic read_reg(input logic [1:0] addr, output logic [15:0] value);
        @(posedge clk);
        cfg_addr_i <= addr;
        @(negedge clk);
        value = cfg_rdata_o;
    endtask

    // random back-pressure with one LFSR step per ready bit.
    task automatic drain_beats(input int n);
        int   beat;
        int   waited;
        logic taken;
        beat = 0;
        while (beat < n && !timed_out) begin
            if (model_addr.size() == 0) begin
                $display("drain asked for more beats than the queue holds");
                errors++;
                test_errors++;
                break;
            end
            taken  = 1'b0;
            waited = 0;
            while (!taken && waited < WAIT_LIMIT) begin
                @(posedge clk);
                lfsr = lfsr_next(lfsr);
                mem_ready_i <= lfsr[0];
                @(negedge clk);
                if (mem_valid_o && mem_ready_i) begin
                    check_hex("mem_addr_o", model_addr[0], mem_addr_o);
                    check_hex("mem_data_o", model_data[0], mem_data_o);
                    void'(model_addr.pop_front());
                    void'(model_data.pop_front());
                    if (model_addr.size() == 0) begin
                        model_burst = 1'b0;
                    end
                    beats_accepted++;
                    taken = 1'b1;
                end
                waited++;
            end
            if (!taken) begin
                $display("timeout: no memory beat was accepted within %0d cycles", WAIT_LIMIT);
                errors++;
                test_errors++;
                timed_out = 1'b1;
            end
            beat++;
        end
        @(posedge clk);
        mem_ready_i <= 1'b0;
    endtask

    // every test ends by comparing the drained register with the beats seen.
    task automatic finish_test();
        logic [15:0] value;
        if (test_active) begin
            read_reg(2'd2, value);
            check_hex("cfg_rdata_o (drained)", beats_accepted[15:0], value);
            tests_run++;
            if (test_errors == 0) begin
                $display("test %0s: passed", test_name);
            end else begin
                $display("test %0s: failed with %0d errors", test_name, test_errors);
                tests_failed++;
            end
        end
        test_errors = 0;
    endtask

    initial begin
        int            fd;
        int            code;
        reg [7:0]      cmd;
        reg [8*128-1:0] junk;
        logic [31:0]   f1;
        logic [31:0]   f2;
        logic [31:0]   f3;
        logic [15:0]   value;
        rst = 1'b1;
        evict_valid_i = 1'b0;
        evict_addr_i = '0;
        evict_data_i = '0;
        lookup_valid_i = 1'b0;
        lookup_tag_i = '0;
        lookup_write_i = 1'b0;
        lookup_wdata_i = '0;
        mem_ready_i = 1'b0;
        cfg_we_i = 1'b0;
        cfg_addr_i = '0;
        cfg_wdata_i = '0;
        model_en = 1'b1;
        model_thr = 4'd1;
        model_burst = 1'b0;
        lfsr = 32'h33b111d4;
        errors = 0;
        test_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        beats_accepted = 0;
        test_active = 1'b0;
        timed_out = 1'b0;
        test_name = "none";
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        fd = $fopen("ewb_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open ewb_tests.txt");
            errors++;
        end else begin
            while (!timed_out) begin
                code = $fscanf(fd, " %c", cmd);
                if (code != 1) begin
                    break;
                end
                case (cmd)
                    "#": code = $fgets(junk, fd);
                    "T": begin
                        finish_test();
                        code = $fscanf(fd, " %s", test_name);
                        test_active = 1'b1;
                    end
                    "E": begin
                        code = $fscanf(fd, " %h %h", f1, f2);
                        evict_line(f1, f2);
                    end
                    "L": begin
                        code = $fscanf(fd, " %h %h %h", f1, f2, f3);
                        lookup_line(f1[26:0], f2[0], f3);
                    end
                    "C": begin
                        code = $fscanf(fd, " %h %h", f1, f2);
                        write_reg(f1[1:0], f2[7:0]);
                    end
                    "R": begin
                        code = $fscanf(fd, " %h %h", f1, f2);
                        read_reg(f1[1:0], value);
                        check_hex("cfg_rdata_o", f2[15:0], value);
                    end
                    "D": begin
                        code = $fscanf(fd, " %h", f1);
                        drain_beats(int'(f1));
                    end
                    default: begin
                        $display("unknown command in the tests file: %c", cmd);
                        errors++;
                        test_errors++;
                    end
                endcase
            end
            $fclose(fd);
            finish_test();
        end
        $display("summary: %0d tests run, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0 && !timed_out) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- ewb_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ewb_consts.svh"

module ewb_top
    import ewb_cfg_pkg::*;
(
    input  wire logic                                          clk,
    input  wire logic                                          rst,

    // eviction port.
    input  wire logic                                          evict_valid_i,
    output logic                                               evict_ready_o,
    input  wire logic [`EWB_ADDR_BITS-1:0]                     evict_addr_i,
    input  wire logic [`EWB_LINE_BITS-1:0]                     evict_data_i,

    // lookup port.
    input  wire logic                                          lookup_valid_i,
    input  wire logic [`EWB_ADDR_BITS-`EWB_OFFSET_BITS-1:0]    lookup_tag_i,
    input  wire logic                                          lookup_write_i,
    input  wire logic [`EWB_LINE_BITS-1:0]                     lookup_wdata_i,
    output logic                                               lookup_hit_o,
    output logic [`EWB_LINE_BITS-1:0]                          lookup_data_o,

    // memory write port.
    output logic                                               mem_valid_o,
    input  wire logic                                          mem_ready_i,
    output logic [`EWB_ADDR_BITS-1:0]                          mem_addr_o,
    output logic [`EWB_LINE_BITS-1:0]                          mem_data_o,

    // register bus.
    input  wire logic                                          cfg_we_i,
    input  wire logic [`EWB_CFG_ADDR_BITS-1:0]                 cfg_addr_i,
    input  wire logic [`EWB_CFG_WDATA_BITS-1:0]                cfg_wdata_i,
    output logic [`EWB_CFG_RDATA_BITS-1:0]                     cfg_rdata_o
);

    logic [`EWB_CNT_BITS-1:0] count;
    logic                     drain_go;
    logic                     drained_pulse;

    ewb_queue u_queue (
        .clk            (clk),
        .rst            (rst),
        .evict_valid_i  (evict_valid_i),
        .evict_ready_o  (evict_ready_o),
        .evict_addr_i   (evict_addr_i),
        .evict_data_i   (evict_data_i),
        .lookup_valid_i (lookup_valid_i),
        .lookup_tag_i   (lookup_tag_i),
        .lookup_write_i (lookup_write_i),
        .lookup_wdata_i (lookup_wdata_i),
        .lookup_hit_o   (lookup_hit_o),
        .lookup_data_o  (lookup_data_o),
        .drain_go_i     (drain_go),
        .mem_valid_o    (mem_valid_o),
        .mem_ready_i    (mem_ready_i),
        .mem_addr_o     (mem_addr_o),
        .mem_data_o     (mem_data_o),
        .count_o        (count),
        .drained_o      (drained_pulse)
    );

    // the bus address arrives as raw bits.
    ewb_cfg_regs u_cfg_regs (
        .clk         (clk),
        .rst         (rst),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_e'(cfg_addr_i)),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_rdata_o (cfg_rdata_o),
        .count_i     (count),
        .mem_valid_i (mem_valid_o),
        .drained_i   (drained_pulse),
        .drain_go_o  (drain_go)
    );

endmodule : ewb_top

`default_nettype wire

//--- ewb_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "ewb_consts.svh"

module ewb_cfg_regs
    import ewb_cfg_pkg::*;
(
    input  wire logic                           clk,
    input  wire logic                           rst,

    // register bus.
    input  wire logic                           cfg_we_i,
    input  wire cfg_addr_e                      cfg_addr_i,
    input  wire logic [`EWB_CFG_WDATA_BITS-1:0] cfg_wdata_i,
    output logic [`EWB_CFG_RDATA_BITS-1:0]      cfg_rdata_o,

    // from the queue.
    input  wire logic [`EWB_CNT_BITS-1:0]       count_i,
    input  wire logic                           mem_valid_i,
    input  wire logic                           drained_i,

    // drain permission back to the queue.
    output logic                                drain_go_o
);

    ewb_ctrl_t                        ctrl_q;
    logic [`EWB_CFG_RDATA_BITS-1:0]   drained_q;
    logic                             hold_q;
    logic [3:0]                       thresh_eff;
    ewb_status_t                      status;

    // control register and drained counter.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctrl_q    <= CTRL_RESET;
            drained_q <= '0;
        end else begin
            if (cfg_we_i && (cfg_addr_i == CFG_CTRL)) begin
                ctrl_q <= ewb_ctrl_t'(cfg_wdata_i);
            end
            if (drained_i) begin
                drained_q <= drained_q + 1'b1;
            end
        end
    end

    // once a beat is offered the queue keeps draining until it runs empty.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hold_q <= 1'b0;
        end else begin
            hold_q <= mem_valid_i;
        end
    end

    // threshold of zero drains as soon as one line is queued.
    assign thresh_eff = (ctrl_q.drain_threshold == 4'd0) ? 4'd1 : ctrl_q.drain_threshold;

    assign drain_go_o = (ctrl_q.drain_en && (count_i >= thresh_eff)) || hold_q;

    assign status.spare = '0;
    assign status.empty = (count_i == '0);
    assign status.full  = (count_i == `EWB_CNT_BITS'(`EWB_DEPTH));
    assign status.count = count_i;

    always_comb begin
        case (cfg_addr_i)
            CFG_CTRL:    cfg_rdata_o = {{(`EWB_CFG_RDATA_BITS-8){1'b0}}, ctrl_q};
            CFG_STATUS:  cfg_rdata_o = status;
            CFG_DRAINED: cfg_rdata_o = drained_q;
            default:     cfg_rdata_o = '0;
        endcase
    end

    // an offered beat that was not taken is still offered on the next cycle.
    a_go_held: assert property (
        @(posedge clk) disable iff (rst)
        (mem_valid_i && !drained_i) |=> (mem_valid_i && drain_go_o)
    ) else $error("drain permission dropped while a beat was offered");

endmodule : ewb_cfg_regs

`default_nettype wire

//--- ewb_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "ewb_consts.svh"

module ewb_queue
    import ewb_types_pkg::*;
(
    input  wire logic                     clk,
    input  wire logic                     rst,

    // eviction side with valid/ready.
    input  wire logic                     evict_valid_i,
    output logic                          evict_ready_o,
    input  wire addr_t                    evict_addr_i,
    input  wire line_t                    evict_data_i,

    // associative lookup from the cache.
    input  wire logic                     lookup_valid_i,
    input  wire line_tag_t                lookup_tag_i,
    input  wire logic                     lookup_write_i,
    input  wire line_t                    lookup_wdata_i,
    output logic                          lookup_hit_o,
    output line_t                         lookup_data_o,

    // drain side with valid/ready.
    input  wire logic                     drain_go_i,
    output logic                          mem_valid_o,
    input  wire logic                     mem_ready_i,
    output addr_t                         mem_addr_o,
    output line_t                         mem_data_o,

    // to the register block.
    output logic [`EWB_CNT_BITS-1:0]      count_o,
    output logic                          drained_o
);

    // entry storage.
    ewb_entry_t mem_q [`EWB_DEPTH];

    logic [`EWB_PTR_BITS-1:0] rd_ptr_q;
    logic [`EWB_PTR_BITS-1:0] wr_ptr_q;
    logic [`EWB_CNT_BITS-1:0] count_q;

    logic full;
    logic empty;
    logic enq;
    logic deq;

    // one bit per physical slot that holds a live entry matching the lookup tag.
    logic [`EWB_DEPTH-1:0] match;

    assign full  = (count_q == `EWB_CNT_BITS'(`EWB_DEPTH));
    assign empty = (count_q == '0);

    // ready never looks at valid.
    assign evict_ready_o = !full;
    assign enq           = evict_valid_i && !full;

    assign mem_valid_o = !empty && drain_go_i;
    assign deq         = mem_valid_o && mem_ready_i;

    // head entry is presented straight from storage.
    assign mem_addr_o = mem_q[rd_ptr_q].addr;
    assign mem_data_o = mem_q[rd_ptr_q].data;

    assign count_o   = count_q;
    assign drained_o = deq;

    // pointers and fill count.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (enq) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (deq) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({enq, deq})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // tag compare against every slot that currently holds a live entry.
    always_comb begin
        logic [`EWB_PTR_BITS-1:0] offset;
        for (int i = 0; i < `EWB_DEPTH; i++) begin
            // distance from the head wraps with the pointer width.
            offset   = `EWB_PTR_BITS'(i) - rd_ptr_q;
            match[i] = lookup_valid_i
                    && ({1'b0, offset} < count_q)
                    && (mem_q[i].addr[`EWB_ADDR_BITS-1:`EWB_OFFSET_BITS] == lookup_tag_i);
        end
    end

    // walk oldest to newest so the newest match is the one left standing.
    always_comb begin
        logic [`EWB_PTR_BITS-1:0] idx;
        lookup_hit_o  = 1'b0;
        lookup_data_o = '0;
        for (int k = 0; k < `EWB_DEPTH; k++) begin
            idx = rd_ptr_q + `EWB_PTR_BITS'(k);
            if (match[idx]) begin
                lookup_hit_o  = 1'b1;
                lookup_data_o = mem_q[idx].data;
            end
        end
    end

    // overwrites and the enqueue never touch the same slot
    // because an enqueue only targets a slot that is not live.
    always_ff @(posedge clk) begin
        if (lookup_write_i) begin
            for (int i = 0; i < `EWB_DEPTH; i++) begin
                if (match[i]) begin
                    mem_q[i].data <= lookup_wdata_i;
                end
            end
        end
        if (enq) begin
            mem_q[wr_ptr_q].addr <= evict_addr_i;
            mem_q[wr_ptr_q].data <= evict_data_i;
        end
    end

    // a refused eviction leaves the write pointer and the head entry alone.
    a_no_enq_full: assert property (
        @(posedge clk) disable iff (rst)
        (evict_valid_i && full && !deq) |=> ($stable(wr_ptr_q) && $stable(mem_addr_o))
    ) else $error("enqueue while full");

    // an offered beat holds until taken unless the cache rewrites the head line.
    a_mem_stable: assert property (
        @(posedge clk) disable iff (rst)
        (mem_valid_o && !mem_ready_i) |=>
            (mem_valid_o && $stable(mem_addr_o)
             && ($stable(mem_data_o) || $past(lookup_write_i && match[rd_ptr_q])))
    ) else $error("memory beat changed before acceptance");

    a_count_bound: assert property (
        @(posedge clk) disable iff (rst)
        count_q <= `EWB_CNT_BITS'(`EWB_DEPTH)
    ) else $error("fill count above depth");

endmodule : ewb_queue

`default_nettype wire

//--- ewb_cfg_pkg.sv
`default_nettype none

`include "ewb_consts.svh"

package ewb_cfg_pkg;

    // register addresses.
    typedef enum logic [`EWB_CFG_ADDR_BITS-1:0] {
        CFG_CTRL    = 2'd0,
        CFG_STATUS  = 2'd1,
        CFG_DRAINED = 2'd2
    } cfg_addr_e;

    // control register, bits 3:1 are spare and read back as written.
    typedef struct packed {
        logic [3:0] drain_threshold;
        logic [2:0] spare;
        logic       drain_en;
    } ewb_ctrl_t;

    // status word as seen on the read bus.
    typedef struct packed {
        logic [`EWB_CFG_RDATA_BITS-`EWB_CNT_BITS-3:0] spare;
        logic                                         empty;
        logic                                         full;
        logic [`EWB_CNT_BITS-1:0]                     count;
    } ewb_status_t;

    // drain enabled, threshold of one line.
    localparam ewb_ctrl_t CTRL_RESET = '{drain_threshold: 4'd1, spare: 3'd0, drain_en: 1'b1};

endpackage : ewb_cfg_pkg

`default_nettype wire

//--- ewb_types_pkg.sv
`default_nettype none

`include "ewb_consts.svh"

package ewb_types_pkg;

    // one cache line of payload.
    typedef logic [`EWB_LINE_BITS-1:0] line_t;

    // full byte address of a line.
    typedef logic [`EWB_ADDR_BITS-1:0] addr_t;

    // address without the offset within the line.
    typedef logic [`EWB_ADDR_BITS-`EWB_OFFSET_BITS-1:0] line_tag_t;

    // one stored eviction.
    typedef struct packed {
        addr_t addr;
        line_t data;
    } ewb_entry_t;

endpackage : ewb_types_pkg

`default_nettype wire

//--- ewb_consts.svh
`ifndef EWB_CONSTS_SVH
`define EWB_CONSTS_SVH

// one evicted cache line, eight 32-bit words.
`define EWB_LINE_BITS 256

// byte address and the offset bits dropped to form a line tag.
`define EWB_ADDR_BITS 32
`define EWB_OFFSET_BITS 5

// queue depth, a power of two so the pointers wrap on their own.
`define EWB_DEPTH 8
`define EWB_PTR_BITS 3
// one bit wider than the pointer so a full queue is visible.
`define EWB_CNT_BITS 4

// register map.
`define EWB_CFG_ADDR_BITS 2
`define EWB_CFG_WDATA_BITS 8
`define EWB_CFG_RDATA_BITS 16

`endif
